// ==== source/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// first word of the text segment, reset value of pc
`define MIPS_TEXT_START 32'h0040_0000

// datapath word width
`define MIPS_WORD_W 32

// register index width and register count
`define MIPS_REG_ADDR_W 5
`define MIPS_NUM_REGS 32

// word address width on the instruction and data ports
// byte address bits [1:0] are dropped
`define MIPS_IADDR_W 30

`endif

// ==== source/mips_pkg.sv ====
`default_nettype none

`include "mips_config.svh"

package mips_pkg;

   typedef logic [`MIPS_WORD_W-1:0] word_t;
   typedef logic [`MIPS_IADDR_W-1:0] waddr_t;
   typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

   // primary opcodes, inst[31:26]
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_BLEZ    = 6'h06,
      OP_BGTZ    = 6'h07,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_t;

   // r-type function codes, inst[5:0]
   typedef enum logic [5:0] {
      F_SLL     = 6'h00,
      F_SRL     = 6'h02,
      F_SRA     = 6'h03,
      F_JR      = 6'h08,
      F_SYSCALL = 6'h0c,
      F_ADD     = 6'h20,
      F_ADDU    = 6'h21,
      F_SUB     = 6'h22,
      F_SUBU    = 6'h23,
      F_AND     = 6'h24,
      F_OR      = 6'h25,
      F_XOR     = 6'h26,
      F_NOR     = 6'h27,
      F_SLT     = 6'h2a
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_t;

   typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ} br_cond_t;

   // source of the address loaded into next_pc
   typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_t;

   typedef enum logic {WB_ALU, WB_MEM} wb_sel_t;

endpackage

`default_nettype wire

// ==== source/mips_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_fetch (
   input  wire                   clk,
   input  wire                   rst_b,
   input  wire                   stall,
   input  wire mips_pkg::pc_sel_t pc_sel,
   input  wire                   branch_taken,
   input  wire mips_pkg::word_t  offset,
   input  wire [25:0]            target,
   input  wire mips_pkg::word_t  rs_data,
   output mips_pkg::word_t       pc
);

   // address of the delay-slot instruction
   mips_pkg::word_t next_pc;
   mips_pkg::word_t seq_addr;
   mips_pkg::word_t new_addr;

   assign seq_addr = next_pc + 32'd4;

   // branch offset is relative to the delay slot
   always_comb
   begin
      case (pc_sel)
         mips_pkg::PC_BRANCH: new_addr = branch_taken ? next_pc + (offset << 2) : seq_addr;
         mips_pkg::PC_JUMP:   new_addr = {pc[31:28], target, 2'b00};
         mips_pkg::PC_REG:    new_addr = rs_data;
         default:             new_addr = seq_addr;
      endcase
   end

   // both counters freeze while halting
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc      <= `MIPS_TEXT_START;
         next_pc <= `MIPS_TEXT_START + 32'd4;
      end
      else if (!stall)
      begin
         pc      <= next_pc;
         next_pc <= new_addr;
      end
   end

   // only jr can bring a misaligned address into the pc pair
   a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_b)
      (pc[1:0] == 2'b00 && next_pc[1:0] == 2'b00 && pc_sel != mips_pkg::PC_REG)
      |=> (pc[1:0] == 2'b00 && next_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== source/mips_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
   input  wire                      clk,
   input  wire                      rst_b,
   input  wire mips_pkg::opcode_t   opcode,
   input  wire mips_pkg::funct_t    funct,
   input  wire mips_pkg::reg_addr_t rt,
   output mips_pkg::alu_op_t        alu_op,
   output mips_pkg::br_cond_t       br_cond,
   output mips_pkg::pc_sel_t        pc_sel,
   output mips_pkg::wb_sel_t        wb_sel,
   output logic                     reg_write,
   output logic                     reg_dst_rd,
   output logic                     alu_src_imm,
   output logic                     sign_ext,
   output logic                     mem_write,
   output logic                     syscall,
   output logic                     reserved
);

   always_comb
   begin
      // defaults describe a no-op that writes nothing
      alu_op      = mips_pkg::ALU_ADD;
      br_cond     = mips_pkg::BR_NONE;
      pc_sel      = mips_pkg::PC_SEQ;
      wb_sel      = mips_pkg::WB_ALU;
      reg_write   = 1'b0;
      reg_dst_rd  = 1'b0;
      alu_src_imm = 1'b0;
      sign_ext    = 1'b0;
      mem_write   = 1'b0;
      syscall     = 1'b0;
      reserved    = 1'b0;
      case (opcode)
         mips_pkg::OP_SPECIAL:
         begin
            // r-type writes rd unless turned off below
            reg_write  = 1'b1;
            reg_dst_rd = 1'b1;
            case (funct)
               mips_pkg::F_ADD, mips_pkg::F_ADDU: alu_op = mips_pkg::ALU_ADD;
               mips_pkg::F_SUB, mips_pkg::F_SUBU: alu_op = mips_pkg::ALU_SUB;
               mips_pkg::F_AND: alu_op = mips_pkg::ALU_AND;
               mips_pkg::F_OR:  alu_op = mips_pkg::ALU_OR;
               mips_pkg::F_XOR: alu_op = mips_pkg::ALU_XOR;
               mips_pkg::F_NOR: alu_op = mips_pkg::ALU_NOR;
               mips_pkg::F_SLT: alu_op = mips_pkg::ALU_SLT;
               mips_pkg::F_SLL: alu_op = mips_pkg::ALU_SLL;
               mips_pkg::F_SRL: alu_op = mips_pkg::ALU_SRL;
               mips_pkg::F_SRA: alu_op = mips_pkg::ALU_SRA;
               mips_pkg::F_JR:
               begin
                  reg_write = 1'b0;
                  pc_sel    = mips_pkg::PC_REG;
               end
               mips_pkg::F_SYSCALL:
               begin
                  reg_write = 1'b0;
                  syscall   = 1'b1;
               end
               default:
               begin
                  reg_write = 1'b0;
                  reserved  = 1'b1;
               end
            endcase
         end
         mips_pkg::OP_J: pc_sel = mips_pkg::PC_JUMP;
         mips_pkg::OP_BEQ, mips_pkg::OP_BNE:
         begin
            pc_sel  = mips_pkg::PC_BRANCH;
            br_cond = (opcode == mips_pkg::OP_BEQ) ? mips_pkg::BR_EQ : mips_pkg::BR_NE;
         end
         // blez and bgtz need rt of zero
         mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ:
         begin
            if (rt == '0)
            begin
               pc_sel  = mips_pkg::PC_BRANCH;
               br_cond = (opcode == mips_pkg::OP_BLEZ) ? mips_pkg::BR_LEZ : mips_pkg::BR_GTZ;
            end
            else
               reserved = 1'b1;
         end
         mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_LW:
         begin
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;
            sign_ext    = 1'b1;
            if (opcode == mips_pkg::OP_SLTI)
               alu_op = mips_pkg::ALU_SLT;
            if (opcode == mips_pkg::OP_LW)
               wb_sel = mips_pkg::WB_MEM;
         end
         // logic immediates stay zero-extended
         mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI:
         begin
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;
            case (opcode)
               mips_pkg::OP_ANDI: alu_op = mips_pkg::ALU_AND;
               mips_pkg::OP_ORI:  alu_op = mips_pkg::ALU_OR;
               mips_pkg::OP_XORI: alu_op = mips_pkg::ALU_XOR;
               default:           alu_op = mips_pkg::ALU_LUI;
            endcase
         end
         mips_pkg::OP_SW:
         begin
            alu_src_imm = 1'b1;
            sign_ext    = 1'b1;
            mem_write   = 1'b1;
         end
         default: reserved = 1'b1;
      endcase
   end

   // a halting instruction writes nothing and raises only one cause
   a_halt_no_write : assert property (@(posedge clk) disable iff (!rst_b)
      (syscall || reserved) |-> !(reg_write || mem_write || (syscall && reserved)));

endmodule

`default_nettype wire

// ==== source/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_regfile (
   input  wire                      clk,
   input  wire                      rst_b,
   input  wire mips_pkg::reg_addr_t rs_addr,
   input  wire mips_pkg::reg_addr_t rt_addr,
   input  wire mips_pkg::reg_addr_t wr_addr,
   input  wire mips_pkg::word_t     wr_data,
   input  wire                      wr_en,
   output mips_pkg::word_t          rs_data,
   output mips_pkg::word_t          rt_data
);

   mips_pkg::word_t regs [`MIPS_NUM_REGS];

   // reads are combinational, new value seen the cycle after the write
   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

   // register zero never takes a write
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         regs <= '{default: '0};
      else if (wr_en && wr_addr != '0)
         regs[wr_addr] <= wr_data;
   end

   a_zero_reg : assert property (@(posedge clk) disable iff (!rst_b)
      (rs_addr == '0) |-> (rs_data == '0));

endmodule

`default_nettype wire

// ==== source/mips_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
   input  wire mips_pkg::word_t    op_a,
   input  wire mips_pkg::word_t    op_b,
   input  wire [4:0]               shamt,
   input  wire mips_pkg::alu_op_t  alu_op,
   input  wire mips_pkg::br_cond_t br_cond,
   output mips_pkg::word_t         result,
   output logic                    branch_taken
);

   // sign bit and zero test shared by blez and bgtz
   logic a_neg;
   logic a_zero;

   assign a_neg  = op_a[31];
   assign a_zero = (op_a == '0);

   always_comb
   begin
      case (alu_op)
         mips_pkg::ALU_ADD: result = op_a + op_b;
         mips_pkg::ALU_SUB: result = op_a - op_b;
         mips_pkg::ALU_AND: result = op_a & op_b;
         mips_pkg::ALU_OR:  result = op_a | op_b;
         mips_pkg::ALU_XOR: result = op_a ^ op_b;
         mips_pkg::ALU_NOR: result = ~(op_a | op_b);
         // signed compare, 0 or 1
         mips_pkg::ALU_SLT: result = mips_pkg::word_t'($signed(op_a) < $signed(op_b));
         // shifts act on rt by shamt
         mips_pkg::ALU_SLL: result = op_b << shamt;
         mips_pkg::ALU_SRL: result = op_b >> shamt;
         mips_pkg::ALU_SRA: result = $signed(op_b) >>> shamt;
         mips_pkg::ALU_LUI: result = {op_b[15:0], 16'h0000};
         default:           result = '0;
      endcase
   end

   // condition is separate from result so branches need no alu_op
   always_comb
   begin
      case (br_cond)
         mips_pkg::BR_EQ:  branch_taken = (op_a == op_b);
         mips_pkg::BR_NE:  branch_taken = (op_a != op_b);
         mips_pkg::BR_LEZ: branch_taken = a_neg || a_zero;
         mips_pkg::BR_GTZ: branch_taken = !a_neg && !a_zero;
         default:          branch_taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== source/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core (
   input  wire             clk,
   input  wire             rst_b,
   input  wire mips_pkg::word_t inst,
   input  wire mips_pkg::word_t mem_rdata,
   output mips_pkg::waddr_t inst_addr,
   output mips_pkg::waddr_t mem_addr,
   output mips_pkg::word_t  mem_wdata,
   output logic             mem_we,
   output logic             halted
);

   // instruction fields
   mips_pkg::opcode_t   opcode;
   mips_pkg::funct_t    funct;
   mips_pkg::reg_addr_t rs;
   mips_pkg::reg_addr_t rt;
   mips_pkg::reg_addr_t rd;
   logic [4:0]          shamt;
   logic [15:0]         imm16;
   mips_pkg::word_t     imm_sext;
   mips_pkg::word_t     imm_ext;

   // control from the decoder
   mips_pkg::alu_op_t   alu_op;
   mips_pkg::br_cond_t  br_cond;
   mips_pkg::pc_sel_t   pc_sel;
   mips_pkg::wb_sel_t   wb_sel;
   logic reg_write;
   logic reg_dst_rd;
   logic alu_src_imm;
   logic sign_ext;
   logic mem_write;
   logic syscall;
   logic reserved;

   // datapath
   mips_pkg::word_t     pc;
   mips_pkg::word_t     rs_data;
   mips_pkg::word_t     rt_data;
   mips_pkg::word_t     op_b;
   mips_pkg::word_t     alu_result;
   mips_pkg::word_t     wb_data;
   mips_pkg::reg_addr_t wr_addr;
   logic branch_taken;
   logic stall;

   assign opcode = mips_pkg::opcode_t'(inst[31:26]);
   assign funct  = mips_pkg::funct_t'(inst[5:0]);
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];
   assign rd     = inst[15:11];
   assign shamt  = inst[10:6];
   assign imm16  = inst[15:0];

   // branches always take the sign-extended offset
   assign imm_sext = {{16{imm16[15]}}, imm16};
   assign imm_ext  = sign_ext ? imm_sext : {16'h0000, imm16};

   assign wr_addr = reg_dst_rd ? rd : rt;
   assign op_b    = alu_src_imm ? imm_ext : rt_data;
   assign wb_data = (wb_sel == mips_pkg::WB_MEM) ? mem_rdata : alu_result;

   // the halting instruction itself and every cycle after it
   assign stall = syscall || reserved || halted;

   assign inst_addr = pc[31:2];
   assign mem_addr  = alu_result[31:2];
   assign mem_wdata = rt_data;
   // no store reaches memory while reset is held
   assign mem_we    = mem_write && !stall && rst_b;

   // sticky until reset
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         halted <= 1'b0;
      else if (syscall || reserved)
         halted <= 1'b1;
   end

   mips_fetch u_fetch (
      .clk(clk), .rst_b(rst_b), .stall(stall), .pc_sel(pc_sel),
      .branch_taken(branch_taken), .offset(imm_sext), .target(inst[25:0]),
      .rs_data(rs_data), .pc(pc)
   );

   mips_decode u_decode (
      .clk(clk), .rst_b(rst_b), .opcode(opcode), .funct(funct), .rt(rt),
      .alu_op(alu_op), .br_cond(br_cond), .pc_sel(pc_sel), .wb_sel(wb_sel),
      .reg_write(reg_write), .reg_dst_rd(reg_dst_rd), .alu_src_imm(alu_src_imm),
      .sign_ext(sign_ext), .mem_write(mem_write), .syscall(syscall),
      .reserved(reserved)
   );

   mips_regfile u_regfile (
      .clk(clk), .rst_b(rst_b), .rs_addr(rs), .rt_addr(rt), .wr_addr(wr_addr),
      .wr_data(wb_data), .wr_en(reg_write && !stall), .rs_data(rs_data),
      .rt_data(rt_data)
   );

   mips_alu u_alu (
      .op_a(rs_data), .op_b(op_b), .shamt(shamt), .alu_op(alu_op),
      .br_cond(br_cond), .result(alu_result), .branch_taken(branch_taken)
   );

   // once halted, no store and the fetch address is frozen
   a_halt_quiet : assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> (!mem_we && $stable(inst_addr)));

endmodule

`default_nettype wire

// ==== test/mips_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_core_tb;

   // primary opcodes
   localparam logic [5:0] OP_SPECIAL = 6'h00;
   localparam logic [5:0] OP_J       = 6'h02;
   localparam logic [5:0] OP_BEQ     = 6'h04;
   localparam logic [5:0] OP_BNE     = 6'h05;
   localparam logic [5:0] OP_BLEZ    = 6'h06;
   localparam logic [5:0] OP_BGTZ    = 6'h07;
   localparam logic [5:0] OP_ADDIU   = 6'h09;
   localparam logic [5:0] OP_SLTI    = 6'h0a;
   localparam logic [5:0] OP_ANDI    = 6'h0c;
   localparam logic [5:0] OP_ORI     = 6'h0d;
   localparam logic [5:0] OP_XORI    = 6'h0e;
   localparam logic [5:0] OP_LUI     = 6'h0f;
   localparam logic [5:0] OP_LW      = 6'h23;
   localparam logic [5:0] OP_SW      = 6'h2b;
   localparam logic [5:0] OP_RSVD    = 6'h3f;

   // r-type function codes
   localparam logic [5:0] F_SLL     = 6'h00;
   localparam logic [5:0] F_SRL     = 6'h02;
   localparam logic [5:0] F_SRA     = 6'h03;
   localparam logic [5:0] F_JR      = 6'h08;
   localparam logic [5:0] F_SYSCALL = 6'h0c;
   localparam logic [5:0] F_ADD     = 6'h20;
   localparam logic [5:0] F_ADDU    = 6'h21;
   localparam logic [5:0] F_SUB     = 6'h22;
   localparam logic [5:0] F_SUBU    = 6'h23;
   localparam logic [5:0] F_AND     = 6'h24;
   localparam logic [5:0] F_OR      = 6'h25;
   localparam logic [5:0] F_XOR     = 6'h26;
   localparam logic [5:0] F_NOR     = 6'h27;
   localparam logic [5:0] F_SLT     = 6'h2a;

   localparam int HALT_TIMEOUT = 1000;
   localparam int MEM_WORDS    = 256;
   localparam mips_pkg::waddr_t TEXT_W = mips_pkg::waddr_t'(`MIPS_TEXT_START >> 2);
   // unused memory reads back as a reserved opcode so a runaway core halts
   localparam mips_pkg::word_t RESERVED_INST = {OP_RSVD, 26'h0};

   logic             clk;
   logic             rst_b;
   mips_pkg::word_t  inst;
   mips_pkg::word_t  mem_rdata;
   mips_pkg::waddr_t inst_addr;
   mips_pkg::waddr_t mem_addr;
   mips_pkg::word_t  mem_wdata;
   logic             mem_we;
   logic             halted;

   mips_pkg::word_t  imem [MEM_WORDS];
   mips_pkg::word_t  dmem [MEM_WORDS];
   mips_pkg::waddr_t imem_index;

   // program builder state and expected data words per store slot
   int              prog_len;
   int              slot_count;
   mips_pkg::word_t exp_slot [MEM_WORDS];

   logic [31:0] lfsr_state;
   int          error_count;
   int          check_count;
   int          test_count;
   int          test_errors;

   mips_core DUT (
      .clk(clk), .rst_b(rst_b), .inst(inst), .mem_rdata(mem_rdata),
      .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_we(mem_we), .halted(halted)
   );

   always #20 clk = ~clk;

   // combinational instruction memory relative to the text segment
   assign imem_index = inst_addr - TEXT_W;
   assign inst = (imem_index < MEM_WORDS) ? imem[imem_index[7:0]] : RESERVED_INST;

   // data memory at byte address zero with combinational read and write at the edge
   assign mem_rdata = dmem[mem_addr[7:0]];

   always @(posedge clk)
   begin
      if (mem_we)
         dmem[mem_addr[7:0]] <= mem_wdata;
   end

   // background value of a data word that no store touched
   function automatic mips_pkg::word_t fill_word(input mips_pkg::waddr_t a);
      return {a, 2'b10} ^ 32'h3c5a_96e1;
   endfunction

   // fibonacci lfsr with taps 32 22 2 1 and one step per bit
   function automatic mips_pkg::word_t rand_bits(input int n);
      mips_pkg::word_t v;
      logic            fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic mips_pkg::word_t enc_r(input logic [5:0] funct,
      input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt,
      input mips_pkg::reg_addr_t rd, input logic [4:0] shamt);
      return {OP_SPECIAL, rs, rt, rd, shamt, funct};
   endfunction

   function automatic mips_pkg::word_t enc_i(input logic [5:0] op,
      input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // jump field holds byte address bits 27..2
   function automatic mips_pkg::word_t enc_j(input logic [5:0] op, input mips_pkg::word_t addr);
      return {op, addr[27:2]};
   endfunction

   task automatic emit(input mips_pkg::word_t w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   // lui then ori
   task automatic load_const(input mips_pkg::reg_addr_t r, input mips_pkg::word_t v);
      emit(enc_i(OP_LUI, 5'd0, r, v[31:16]));
      emit(enc_i(OP_ORI, r, r, v[15:0]));
   endtask

   // sw r into the next slot, which must end up holding v
   task automatic store_expect(input mips_pkg::reg_addr_t r, input mips_pkg::word_t v);
      emit(enc_i(OP_SW, 5'd0, r, 16'(slot_count * 4)));
      exp_slot[slot_count] = v;
      slot_count++;
   endtask

   // sw that must never execute so its slot keeps the fill value
   task automatic store_skipped(input mips_pkg::reg_addr_t r);
      emit(enc_i(OP_SW, 5'd0, r, 16'(slot_count * 4)));
      exp_slot[slot_count] = fill_word(mips_pkg::waddr_t'(slot_count));
      slot_count++;
   endtask

   task automatic new_program();
      prog_len   = 0;
      slot_count = 0;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         imem[i] = RESERVED_INST;
         dmem[i] = fill_word(mips_pkg::waddr_t'(i));
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst_b <= 1'b0;
      repeat (8) @(posedge clk);
      rst_b <= 1'b1;
   endtask

   task automatic wait_halt(output bit done);
      int cycles;
      done   = 1'b0;
      cycles = 0;
      while (!done && cycles < HALT_TIMEOUT)
      begin
         @(negedge clk);
         if (halted)
            done = 1'b1;
         else
            cycles++;
      end
      if (!done)
      begin
         $display("core did not halt within %0d cycles", HALT_TIMEOUT);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic run_program(output bit done);
      apply_reset();
      wait_halt(done);
   endtask

   task automatic check_word(input mips_pkg::word_t got, input mips_pkg::word_t exp,
      input string what);
      check_count++;
      if (got !== exp)
      begin
         $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic check_addr(input mips_pkg::waddr_t got, input mips_pkg::waddr_t exp,
      input string what);
      check_count++;
      if (got !== exp)
      begin
         $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      check_count++;
      if (got !== exp)
      begin
         $display("** Error at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic check_slots();
      for (int s = 0; s < slot_count; s++)
         check_word(dmem[s], exp_slot[s], $sformatf("data word %0d", s));
   endtask

   task automatic begin_test();
      test_errors = 0;
      test_count++;
   endtask

   task automatic end_test(input string name);
      if (test_errors == 0)
         $display("test %s passed", name);
      else
         $display("test %s failed with %0d errors", name, test_errors);
   endtask

   // alu result goes to $3 and is then stored
   task automatic r_case(input logic [5:0] funct, input mips_pkg::reg_addr_t rs,
      input mips_pkg::reg_addr_t rt, input logic [4:0] shamt, input mips_pkg::word_t exp);
      emit(enc_r(funct, rs, rt, 5'd3, shamt));
      store_expect(5'd3, exp);
   endtask

   task automatic i_case(input logic [5:0] op, input mips_pkg::reg_addr_t rs,
      input logic [15:0] imm, input mips_pkg::word_t exp);
      emit(enc_i(op, rs, 5'd3, imm));
      store_expect(5'd3, exp);
   endtask

   // control instruction, delay slot, skipped slot, target
   // branches use offset 2 so target lands three words after the branch
   task automatic flow_case(input mips_pkg::word_t ctl, input bit taken,
      input mips_pkg::word_t marker);
      emit(ctl);
      store_expect(5'd9, marker);
      if (taken)
         store_skipped(5'd9);
      else
         store_expect(5'd9, marker);
      store_expect(5'd9, marker);
   endtask

   task automatic test_reset();
      bit done;
      begin_test();
      new_program();
      // a store first so mem_we has something to hold back during reset
      store_expect(5'd0, 32'd0);
      emit(enc_r(F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      @(posedge clk);
      rst_b <= 1'b0;
      repeat (7) @(posedge clk);
      // sampled between edges with reset still held
      @(negedge clk);
      check_addr(inst_addr, TEXT_W, "fetch address in reset");
      check_flag(halted, 1'b0, "halted in reset");
      check_flag(mem_we, 1'b0, "mem_we in reset");
      @(posedge clk);
      rst_b <= 1'b1;
      wait_halt(done);
      check_slots();
      end_test("reset");
   endtask

   task automatic test_rtype();
      mips_pkg::word_t a;
      mips_pkg::word_t b;
      mips_pkg::word_t bn;
      logic [4:0]      sh;
      bit              done;
      begin_test();
      a  = rand_bits(32);
      b  = rand_bits(32);
      bn = rand_bits(32) | 32'h8000_0000;
      sh = rand_bits(5);
      new_program();
      load_const(5'd1, a);
      load_const(5'd2, b);
      load_const(5'd4, bn);
      r_case(F_ADD, 5'd1, 5'd2, 5'd0, a + b);
      r_case(F_ADDU, 5'd1, 5'd4, 5'd0, a + bn);
      r_case(F_SUB, 5'd1, 5'd2, 5'd0, a - b);
      r_case(F_SUBU, 5'd2, 5'd1, 5'd0, b - a);
      r_case(F_AND, 5'd1, 5'd2, 5'd0, a & b);
      r_case(F_OR, 5'd1, 5'd2, 5'd0, a | b);
      r_case(F_XOR, 5'd1, 5'd2, 5'd0, a ^ b);
      r_case(F_NOR, 5'd1, 5'd2, 5'd0, ~(a | b));
      // signed compare both ways since bn is negative
      r_case(F_SLT, 5'd1, 5'd2, 5'd0, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
      r_case(F_SLT, 5'd4, 5'd1, 5'd0, ($signed(bn) < $signed(a)) ? 32'd1 : 32'd0);
      r_case(F_SLT, 5'd1, 5'd4, 5'd0, ($signed(a) < $signed(bn)) ? 32'd1 : 32'd0);
      r_case(F_SLL, 5'd0, 5'd2, sh, b << sh);
      r_case(F_SRL, 5'd0, 5'd4, sh, bn >> sh);
      // bn is negative so sra fills the vacated upper bits with ones
      r_case(F_SRA, 5'd0, 5'd4, sh, (bn >> sh) | ~(32'hffff_ffff >> sh));
      r_case(F_SRA, 5'd0, 5'd1, 5'd31, {32{a[31]}});
      emit(enc_r(F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program(done);
      check_slots();
      end_test("r-type");
   endtask

   task automatic test_imm();
      mips_pkg::word_t a;
      mips_pkg::word_t sx;
      logic [15:0]     imm;
      bit              done;
      begin_test();
      a   = rand_bits(32);
      imm = rand_bits(16) | 16'h8000;
      sx  = {{16{imm[15]}}, imm};
      new_program();
      load_const(5'd1, a);
      load_const(5'd5, 32'hffff_fffb);
      i_case(OP_ADDIU, 5'd1, imm, a + sx);
      i_case(OP_SLTI, 5'd1, imm, ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0);
      // -5 against 3 and against -16
      i_case(OP_SLTI, 5'd5, 16'd3, 32'd1);
      i_case(OP_SLTI, 5'd5, 16'hfff0, 32'd0);
      i_case(OP_ANDI, 5'd1, imm, a & {16'h0000, imm});
      i_case(OP_ORI, 5'd1, imm, a | {16'h0000, imm});
      i_case(OP_XORI, 5'd1, imm, a ^ {16'h0000, imm});
      i_case(OP_LUI, 5'd0, imm, {imm, 16'h0000});
      // writes aimed at $0 are dropped
      emit(enc_i(OP_ADDIU, 5'd1, 5'd0, imm));
      emit(enc_r(F_ADDU, 5'd1, 5'd1, 5'd0, 5'd0));
      store_expect(5'd0, 32'd0);
      emit(enc_r(F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program(done);
      check_slots();
      end_test("immediate");
   endtask

   task automatic test_load_store();
      mips_pkg::word_t v;
      bit              done;
      begin_test();
      v = rand_bits(32);
      new_program();
      dmem[20] = v;
      emit(enc_i(OP_LW, 5'd0, 5'd6, 16'd80));
      emit(enc_i(OP_SW, 5'd0, 5'd6, 16'd84));
      // base register 64 with positive and negative offsets
      load_const(5'd7, 32'd64);
      emit(enc_i(OP_LW, 5'd7, 5'd8, 16'd16));
      emit(enc_i(OP_SW, 5'd7, 5'd8, 16'd24));
      emit(enc_i(OP_SW, 5'd7, 5'd8, 16'hfffc));
      emit(enc_r(F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program(done);
      check_word(dmem[21], v, "sw of loaded word");
      check_word(dmem[22], v, "sw with base register");
      check_word(dmem[15], v, "sw with negative offset");
      check_word(dmem[23], fill_word(30'd23), "untouched neighbour word");
      end_test("load/store");
   endtask

   task automatic test_control();
      mips_pkg::word_t marker;
      mips_pkg::word_t target;
      bit              done;
      begin_test();
      marker = rand_bits(32);
      new_program();
      emit(enc_i(OP_ADDIU, 5'd0, 5'd1, 16'd5));
      emit(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'd5));
      emit(enc_i(OP_ADDIU, 5'd0, 5'd3, 16'd7));
      emit(enc_i(OP_ADDIU, 5'd0, 5'd4, 16'hfffd));
      load_const(5'd9, marker);
      flow_case(enc_i(OP_BEQ, 5'd1, 5'd2, 16'd2), 1'b1, marker);
      flow_case(enc_i(OP_BEQ, 5'd1, 5'd3, 16'd2), 1'b0, marker);
      flow_case(enc_i(OP_BNE, 5'd1, 5'd3, 16'd2), 1'b1, marker);
      flow_case(enc_i(OP_BNE, 5'd1, 5'd2, 16'd2), 1'b0, marker);
      // blez and bgtz on negative, zero and positive
      flow_case(enc_i(OP_BLEZ, 5'd4, 5'd0, 16'd2), 1'b1, marker);
      flow_case(enc_i(OP_BLEZ, 5'd0, 5'd0, 16'd2), 1'b1, marker);
      flow_case(enc_i(OP_BLEZ, 5'd1, 5'd0, 16'd2), 1'b0, marker);
      flow_case(enc_i(OP_BGTZ, 5'd1, 5'd0, 16'd2), 1'b1, marker);
      flow_case(enc_i(OP_BGTZ, 5'd4, 5'd0, 16'd2), 1'b0, marker);
      flow_case(enc_i(OP_BGTZ, 5'd0, 5'd0, 16'd2), 1'b0, marker);
      target = `MIPS_TEXT_START + 4 * (prog_len + 3);
      flow_case(enc_j(OP_J, target), 1'b1, marker);
      // jr sits two words after the constant load
      target = `MIPS_TEXT_START + 4 * (prog_len + 5);
      load_const(5'd10, target);
      flow_case(enc_r(F_JR, 5'd10, 5'd0, 5'd0, 5'd0), 1'b1, marker);
      emit(enc_r(F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program(done);
      check_slots();
      end_test("control flow");
   endtask

   task automatic test_halt();
      int  halt_at;
      bit  done;
      begin_test();
      new_program();
      emit(enc_i(OP_ADDIU, 5'd0, 5'd1, 16'h0055));
      halt_at = prog_len;
      emit(enc_r(F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      store_skipped(5'd1);
      run_program(done);
      if (done)
      begin
         check_addr(inst_addr, mips_pkg::waddr_t'(TEXT_W + halt_at), "syscall address");
         // the halted core now faces a store in place of the syscall
         imem[halt_at] = imem[halt_at + 1];
         repeat (10)
         begin
            @(negedge clk);
            check_flag(halted, 1'b1, "halted after syscall");
            check_flag(mem_we, 1'b0, "mem_we while halted");
            check_addr(inst_addr, mips_pkg::waddr_t'(TEXT_W + halt_at), "frozen fetch address");
         end
      end
      check_slots();
      // second program halts on a reserved opcode
      new_program();
      emit(enc_i(OP_ADDIU, 5'd0, 5'd1, 16'h00aa));
      halt_at = prog_len;
      emit(enc_i(OP_RSVD, 5'd0, 5'd0, 16'h0000));
      store_skipped(5'd1);
      run_program(done);
      if (done)
         check_addr(inst_addr, mips_pkg::waddr_t'(TEXT_W + halt_at), "reserved opcode address");
      repeat (4) @(negedge clk);
      check_slots();
      end_test("halt");
   endtask

   initial
   begin
      clk         = 1'b0;
      rst_b       = 1'b0;
      lfsr_state  = 32'h9a2e_16a3;
      error_count = 0;
      check_count = 0;
      test_count  = 0;
      test_errors = 0;
      new_program();

      test_reset();
      test_rtype();
      test_imm();
      test_load_store();
      test_control();
      test_halt();

      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== mips_core.f ====
+incdir+source
source/mips_pkg.sv
source/mips_fetch.sv
source/mips_decode.sv
source/mips_regfile.sv
source/mips_alu.sv
source/mips_core.sv
test/mips_core_tb.sv
